//--- bench/lsu_slice_tb.sv
`default_nettype none

`include "lsu_defs.svh"

module lsu_slice_tb
    import lsu_op_pkg::*, lsu_bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          COLS    = 7;
    localparam int          MAX_OPS = 64;
    localparam logic [31:0] SEED    = 32'h8a5349dc;

    logic                                       clk = 1'b1;
    logic                                       reset;
    logic                                       issue_valid;
    logic                                       issue_ready;
    issue_req_t                                 issue_req;
    logic                                       wb_cyc;
    logic                                       wb_stb;
    logic                                       wb_we;
    logic [`LSU_ADDR_WIDTH-`LSU_ALIGN_BITS-1:0] wb_adr;
    logic [`LSU_WORD_BYTES-1:0]                 wb_sel;
    logic [`LSU_XLEN-1:0]                       wb_dat_w;
    logic                                       wb_ack;
    logic [`LSU_XLEN-1:0]                       wb_dat_r;
    logic                                       result_valid;
    logic                                       result_ready;
    lsu_result_t                                result;
    logic [1:0]                                 ack_delay;

    logic [31:0] vec [COLS*MAX_OPS];
    lsu_result_t exp_results [$];
    bus_req_t    exp_bus [$];
    int          n_ops = 0;
    int          n_done = 0;
    int          cycles = 0;
    int          limit = 0;
    int          pending = 0;
    int          pending_prev = 0;
    logic        cyc_prev = 1'b0;

    lsu_slice UUT (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_req    (issue_req),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_sel       (wb_sel),
        .wb_dat_w     (wb_dat_w),
        .wb_ack       (wb_ack),
        .wb_dat_r     (wb_dat_r),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    wb_mem_model mem (
        .clk       (clk),
        .reset     (reset),
        .ack_delay (ack_delay),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_w  (wb_dat_w),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r)
    );

    always #5 clk = ~clk;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_result(input lsu_result_t got);
        lsu_result_t want;
        if (exp_results.size() == 0) begin
            stop_with_error("a result arrived with no instruction outstanding");
        end else begin
            want = exp_results.pop_front();
            if (got !== want) begin
                stop_with_error($sformatf("mismatch result: got %h expected %h", got, want));
            end
        end
    endtask

    task automatic check_bus(input bus_req_t got);
        bus_req_t want;
        if (exp_bus.size() == 0) begin
            stop_with_error("a Wishbone cycle ran with no access outstanding");
        end else begin
            want = exp_bus.pop_front();
            if (got !== want) begin
                stop_with_error($sformatf(
                    "mismatch {wb_we,wb_adr,wb_sel,wb_dat_w}: got %h expected %h", got, want));
            end
        end
    endtask

    // reference for the bus request of one operation
    function automatic bus_req_t expected_bus(lsu_op_t op, logic [31:0] rs1,
                                              logic [11:0] offset, logic [31:0] rs2);
        logic [31:0] addr;
        bus_req_t    r;
        addr  = rs1 + {{20{offset[11]}}, offset};
        r.we  = op inside {SB, SH, SW};
        r.adr = addr[31:2];
        case (op)
            LB, LBU, SB: r.sel = 4'b0001 << addr[1:0];
            LH, LHU, SH: r.sel = 4'b0011 << addr[1:0];
            default:     r.sel = 4'b1111;
        endcase
        r.dat = rs2 << (8 * addr[1:0]);
        return r;
    endfunction

    // random ready and ack delay, one draw each per falling edge
    initial begin
        result_ready = 1'b0;
        ack_delay    = 2'd0;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            result_ready = ($urandom % 2) == 0;
            ack_delay    <= 2'($urandom % 4);
        end
    end

    always @(posedge clk) begin
        bus_req_t got_bus;
        cycles++;
        if (limit > 0 && cycles > limit) begin
            stop_with_error($sformatf("timeout after %0d cycles with %0d of %0d results",
                                      limit, n_done, n_ops));
        end
        if (!reset) begin
            if (wb_stb && wb_ack) begin
                got_bus.we  = wb_we;
                got_bus.adr = wb_adr;
                got_bus.sel = wb_sel;
                got_bus.dat = wb_dat_w;
                check_bus(got_bus);
            end
            if (result_valid && result_ready) begin
                check_result(result);
                n_done++;
            end
            // a cycle that began at the previous edge needed room for its result
            if (wb_cyc && !cyc_prev && pending_prev > 1) begin
                stop_with_error("a bus cycle started while two results were waiting");
            end
            pending_prev = pending;
            if (wb_stb && wb_ack) begin
                pending++;
            end
            if (result_valid && result_ready) begin
                pending--;
            end
            cyc_prev = wb_cyc;
        end
    end

    initial begin
        int          base;
        issue_req_t  req;
        lsu_result_t res;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_req   = '0;
        for (int i = 0; i < COLS*MAX_OPS; i++) begin
            vec[i] = '1;
        end
        $readmemh("bench/lsu_slice_testdata.txt", vec);
        while (n_ops < MAX_OPS && vec[n_ops*COLS] != '1) begin
            n_ops++;
        end
        if (n_ops == 0) begin
            stop_with_error("the data file holds no operations");
        end
        limit = n_ops * 12 + 100;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (!issue_ready || wb_cyc || wb_stb || result_valid) begin
            stop_with_error("interface not idle one cycle after reset");
        end

        for (int i = 0; i < n_ops; i++) begin
            base       = i * COLS;
            req.uuid   = 8'(i);
            req.wid    = 2'(i);
            req.pc     = 32'h1000 + 32'(4 * i);
            req.op     = lsu_op_t'(vec[base][2:0]);
            req.rs1    = vec[base+1];
            req.offset = vec[base+2][11:0];
            req.rs2    = vec[base+3];
            req.rd     = vec[base+4][4:0];
            req.wb     = vec[base+5][0];
            res.uuid   = req.uuid;
            res.wid    = req.wid;
            res.pc     = req.pc;
            res.rd     = req.rd;
            // stores complete without writeback
            res.wb     = req.wb && !(req.op inside {SB, SH, SW});
            res.data   = vec[base+6];
            issue_req   = req;
            issue_valid = 1'b1;
            @(posedge clk);
            while (!issue_ready) begin
                @(posedge clk);
            end
            exp_results.push_back(res);
            exp_bus.push_back(expected_bus(req.op, req.rs1, req.offset, req.rs2));
            @(negedge clk);
        end
        issue_valid = 1'b0;

        wait (n_done == n_ops);
        @(negedge clk);
        if (exp_results.size() != 0 || exp_bus.size() != 0) begin
            stop_with_error("expected responses still outstanding at the end");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/lsu_slice_testdata.txt
// op rs1 offset rs2 rd wb expected_data, all hex, offset is the 12-bit immediate
// op: 0 lb, 1 lh, 2 lw, 3 lbu, 4 lhu, 5 sb, 6 sh, 7 sw
7 00000100 000 12345678 01 1 00000000
2 00000100 000 00000000 05 1 12345678
7 00000110 000 a1b2c3d4 02 1 00000000
5 00000110 000 00000011 00 0 00000000
5 00000110 001 00000022 00 1 00000000
5 00000110 002 deadbe80 00 1 00000000
5 00000110 003 00000044 00 1 00000000
2 00000110 000 00000000 06 1 44802211
0 00000110 002 00000000 07 1 ffffff80
3 00000110 002 00000000 08 1 00000080
0 00000110 001 00000000 09 1 00000022
3 00000110 003 00000000 0a 1 00000044
7 00000120 000 00000000 00 1 00000000
6 00000120 000 00008001 00 1 00000000
6 00000120 002 12347fff 00 1 00000000
1 00000120 000 00000000 0b 1 ffff8001
4 00000120 000 00000000 0c 1 00008001
1 00000120 002 00000000 0d 1 00007fff
2 00000120 000 00000000 0e 1 7fff8001
7 00000140 ff8 cafef00d 00 1 00000000
2 00000138 000 00000000 0f 1 cafef00d
0 0000013c ffd 00000000 10 1 fffffff0
4 0000013c ffe 00000000 11 0 0000cafe
0 00000110 000 00000000 12 1 00000011

//--- bench/wb_mem_model.sv
`default_nettype none

`include "lsu_defs.svh"

module wb_mem_model (
    input  wire                                       clk,
    input  wire                                       reset,
    input  wire  [1:0]                                ack_delay,

    input  wire                                       wb_cyc,
    input  wire                                       wb_stb,
    input  wire                                       wb_we,
    input  wire  [`LSU_ADDR_WIDTH-`LSU_ALIGN_BITS-1:0] wb_adr,
    input  wire  [`LSU_WORD_BYTES-1:0]                wb_sel,
    input  wire  [`LSU_XLEN-1:0]                      wb_dat_w,
    output logic                                      wb_ack,
    output logic [`LSU_XLEN-1:0]                      wb_dat_r
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`LSU_XLEN-1:0] mem [256];
    logic [7:0]           idx;
    logic                 busy;
    logic [1:0]           wait_left;

    assign idx = wb_adr[7:0];

    always @(negedge clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            wb_dat_r  <= '0;
            busy      <= 1'b0;
            wait_left <= 2'd0;
            // fill uses every address bit
            for (int i = 0; i < 256; i++) begin
                mem[i] <= {8'(i) ^ 8'hc3, 8'(i), ~8'(i), 8'(i) ^ 8'h5a};
            end
        end else if (wb_ack) begin
            // master drops stb on the edge that took the ack
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy && ack_delay != 2'd0) begin
                busy      <= 1'b1;
                wait_left <= ack_delay - 2'd1;
            end else if (busy && wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                busy     <= 1'b0;
                wb_ack   <= 1'b1;
                wb_dat_r <= mem[idx];
                if (wb_we) begin
                    for (int b = 0; b < `LSU_WORD_BYTES; b++) begin
                        if (wb_sel[b]) begin
                            mem[idx][8*b +: 8] <= wb_dat_w[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
src/lsu_op_pkg.sv
src/lsu_bus_pkg.sv
src/lsu_elastic_buf.sv
src/lsu_addr_stage.sv
src/lsu_bus_stage.sv
src/lsu_rsp_stage.sv
src/lsu_slice.sv
bench/wb_mem_model.sv
bench/lsu_slice_tb.sv

//--- include/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// datapath
`define LSU_XLEN          32
`define LSU_ADDR_WIDTH    32
`define LSU_WORD_BYTES    4
`define LSU_ALIGN_BITS    2

// immediate field of a load or store
`define LSU_OFFSET_WIDTH  12

// instruction tracking fields
`define LSU_UUID_WIDTH    8
`define LSU_WID_WIDTH     2
`define LSU_PC_WIDTH      32
`define LSU_REG_BITS      5

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the load/store slice testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module lsu_slice_tb \
    --Mdir obj_dir -o lsu_slice_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/lsu_slice_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0

//--- src/lsu_addr_stage.sv
`default_nettype none

`include "lsu_defs.svh"

module lsu_addr_stage
    import lsu_op_pkg::*, lsu_bus_pkg::*;
(
    input  wire issue_req_t req,
    output staged_access_t  access
);
    localparam int PAD_BITS = `LSU_XLEN - `LSU_OFFSET_WIDTH;

    logic [`LSU_XLEN-1:0]       offset_ext;
    logic [`LSU_XLEN-1:0]       eff_addr;
    logic [`LSU_ALIGN_BITS-1:0] align;
    logic [`LSU_WORD_BYTES-1:0] sel;
    logic [`LSU_XLEN-1:0]       store_data;

    // effective address
    assign offset_ext = {{PAD_BITS{req.offset[`LSU_OFFSET_WIDTH-1]}}, req.offset};
    assign eff_addr   = req.rs1 + offset_ext;
    assign align      = eff_addr[`LSU_ALIGN_BITS-1:0];

    // byte lanes touched by the access
    always_comb begin
        case (op_size(req.op))
            2'd0: begin
                sel = `LSU_WORD_BYTES'(1) << align;
            end
            2'd1: begin
                sel = `LSU_WORD_BYTES'(3) << {align[1], 1'b0};
            end
            default: begin
                sel = '1;
            end
        endcase
    end

    // low bytes of rs2 moved up to their lanes
    assign store_data = req.rs2 << {align, 3'b000};

    always_comb begin
        access.req.we  = op_is_store(req.op);
        access.req.adr = eff_addr[`LSU_ADDR_WIDTH-1:`LSU_ALIGN_BITS];
        access.req.sel = sel;
        access.req.dat = store_data;

        access.ctx.uuid  = req.uuid;
        access.ctx.wid   = req.wid;
        access.ctx.pc    = req.pc;
        access.ctx.rd    = req.rd;
        access.ctx.wb    = req.wb;
        access.ctx.op    = req.op;
        access.ctx.align = align;
    end

endmodule

`default_nettype wire

//--- src/lsu_bus_pkg.sv
`default_nettype none

`include "lsu_defs.svh"

package lsu_bus_pkg;

    import lsu_op_pkg::*;

    // one Wishbone classic request, word addressed
    typedef struct packed {
        logic                                      we;
        logic [`LSU_ADDR_WIDTH-`LSU_ALIGN_BITS-1:0] adr;
        logic [`LSU_WORD_BYTES-1:0]                sel;
        logic [`LSU_XLEN-1:0]                      dat;
    } bus_req_t;

    // kept beside the single outstanding access in place of a tag
    typedef struct packed {
        logic [`LSU_UUID_WIDTH-1:0] uuid;
        logic [`LSU_WID_WIDTH-1:0]  wid;
        logic [`LSU_PC_WIDTH-1:0]   pc;
        logic [`LSU_REG_BITS-1:0]   rd;
        logic                       wb;
        lsu_op_t                    op;
        logic [`LSU_ALIGN_BITS-1:0] align;
    } access_ctx_t;

    typedef struct packed {
        bus_req_t    req;
        access_ctx_t ctx;
    } staged_access_t;

endpackage

`default_nettype wire

//--- src/lsu_bus_stage.sv
`default_nettype none

`include "lsu_defs.svh"

module lsu_bus_stage
    import lsu_bus_pkg::*;
(
    input  wire                                       clk,
    input  wire                                       reset,

    input  wire                                       in_valid,
    output logic                                      in_ready,
    input  wire staged_access_t                       in_access,

    output logic                                      wb_cyc,
    output logic                                      wb_stb,
    output logic                                      wb_we,
    output logic [`LSU_ADDR_WIDTH-`LSU_ALIGN_BITS-1:0] wb_adr,
    output logic [`LSU_WORD_BYTES-1:0]                wb_sel,
    output logic [`LSU_XLEN-1:0]                      wb_dat_w,
    input  wire                                       wb_ack,
    input  wire  [`LSU_XLEN-1:0]                      wb_dat_r,

    output logic                                      done_valid,
    input  wire                                       done_ready,
    output access_ctx_t                               done_ctx,
    output logic [`LSU_XLEN-1:0]                      done_word
);
    typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_DONE} state_t;

    state_t               state;
    bus_req_t             req_q;
    access_ctx_t          ctx_q;
    logic [`LSU_XLEN-1:0] word_q;
    logic                 start;
    logic                 ack_fire;

    // only start when the result buffer has room for the outcome
    assign in_ready = (state == ST_IDLE) && done_ready;
    assign start    = in_valid && in_ready;

    assign wb_cyc   = (state == ST_BUS);
    assign wb_stb   = (state == ST_BUS);
    assign wb_we    = req_q.we;
    assign wb_adr   = req_q.adr;
    assign wb_sel   = req_q.sel;
    assign wb_dat_w = req_q.dat;
    assign ack_fire = wb_stb && wb_ack;

    // the acked word passes straight on, or waits here until taken
    assign done_valid = ack_fire || (state == ST_DONE);
    assign done_word  = (state == ST_DONE) ? word_q : wb_dat_r;
    assign done_ctx   = ctx_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (start) state <= ST_BUS;
                ST_BUS:  if (wb_ack) state <= done_ready ? ST_IDLE : ST_DONE;
                ST_DONE: if (done_ready) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_q <= in_access.req;
            ctx_q <= in_access.ctx;
        end
        if (ack_fire && !done_ready) begin
            word_q <= wb_dat_r;
        end
    end

endmodule

`default_nettype wire

//--- src/lsu_elastic_buf.sv
`default_nettype none

module lsu_elastic_buf #(
    parameter type payload_t = logic [31:0]
) (
    input  wire           clk,
    input  wire           reset,

    input  wire           in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,

    output logic          out_valid,
    input  wire           out_ready,
    output payload_t      out_data
);
    payload_t   entry [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // ready comes from the fill level only, so out_ready never reaches in_ready
    assign in_ready  = ~count[1];
    assign out_valid = (count != 2'd0);
    assign out_data  = entry[rd_ptr];

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- src/lsu_op_pkg.sv
`default_nettype none

`include "lsu_defs.svh"

package lsu_op_pkg;

    // encodings shared with the instruction decoder
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } lsu_op_t;

    typedef struct packed {
        logic [`LSU_UUID_WIDTH-1:0]   uuid;
        logic [`LSU_WID_WIDTH-1:0]    wid;
        logic [`LSU_PC_WIDTH-1:0]     pc;
        logic [`LSU_REG_BITS-1:0]     rd;
        logic                         wb;
        lsu_op_t                      op;
        logic [`LSU_XLEN-1:0]         rs1;
        logic [`LSU_XLEN-1:0]         rs2;
        logic [`LSU_OFFSET_WIDTH-1:0] offset;
    } issue_req_t;

    typedef struct packed {
        logic [`LSU_UUID_WIDTH-1:0] uuid;
        logic [`LSU_WID_WIDTH-1:0]  wid;
        logic [`LSU_PC_WIDTH-1:0]   pc;
        logic [`LSU_REG_BITS-1:0]   rd;
        logic                       wb;
        logic [`LSU_XLEN-1:0]       data;
    } lsu_result_t;

    function automatic logic op_is_store(lsu_op_t op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

    // log2 of the access size in bytes
    function automatic logic [1:0] op_size(lsu_op_t op);
        case (op)
            LB, LBU, SB: return 2'd0;
            LH, LHU, SH: return 2'd1;
            default:     return 2'd2;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/lsu_rsp_stage.sv
`default_nettype none

`include "lsu_defs.svh"

module lsu_rsp_stage
    import lsu_op_pkg::*, lsu_bus_pkg::*;
(
    input  wire access_ctx_t          ctx,
    input  wire [`LSU_XLEN-1:0]       word,
    output lsu_result_t               result
);
    localparam int HALF = `LSU_XLEN / 2;

    logic [HALF-1:0]      half_val;
    logic [7:0]           byte_val;
    logic [`LSU_XLEN-1:0] load_data;
    logic                 is_store;

    // pick the addressed lanes out of the word
    assign half_val = ctx.align[1] ? word[`LSU_XLEN-1:HALF] : word[HALF-1:0];
    assign byte_val = ctx.align[0] ? half_val[15:8] : half_val[7:0];
    assign is_store = op_is_store(ctx.op);

    always_comb begin
        case (ctx.op)
            LB: begin
                load_data = {{(`LSU_XLEN-8){byte_val[7]}}, byte_val};
            end
            LH: begin
                load_data = {{(`LSU_XLEN-HALF){half_val[HALF-1]}}, half_val};
            end
            LW: begin
                load_data = word;
            end
            LBU: begin
                load_data = {{(`LSU_XLEN-8){1'b0}}, byte_val};
            end
            LHU: begin
                load_data = {{(`LSU_XLEN-HALF){1'b0}}, half_val};
            end
            // stores complete with no data
            default: begin
                load_data = '0;
            end
        endcase
    end

    always_comb begin
        result.uuid = ctx.uuid;
        result.wid  = ctx.wid;
        result.pc   = ctx.pc;
        result.rd   = ctx.rd;
        result.wb   = ctx.wb && !is_store;
        result.data = load_data;
    end

endmodule

`default_nettype wire

//--- src/lsu_slice.sv
`default_nettype none

`include "lsu_defs.svh"

module lsu_slice
    import lsu_op_pkg::*, lsu_bus_pkg::*;
(
    input  wire                                       clk,
    input  wire                                       reset,

    input  wire                                       issue_valid,
    output logic                                      issue_ready,
    input  wire issue_req_t                           issue_req,

    output logic                                      wb_cyc,
    output logic                                      wb_stb,
    output logic                                      wb_we,
    output logic [`LSU_ADDR_WIDTH-`LSU_ALIGN_BITS-1:0] wb_adr,
    output logic [`LSU_WORD_BYTES-1:0]                wb_sel,
    output logic [`LSU_XLEN-1:0]                      wb_dat_w,
    input  wire                                       wb_ack,
    input  wire  [`LSU_XLEN-1:0]                      wb_dat_r,

    output logic                                      result_valid,
    input  wire                                       result_ready,
    output lsu_result_t                               result
);
    staged_access_t       addr_access;
    staged_access_t       buf_access;
    logic                 buf_valid;
    logic                 buf_ready;
    logic                 done_valid;
    logic                 done_ready;
    access_ctx_t          done_ctx;
    logic [`LSU_XLEN-1:0] done_word;
    lsu_result_t          rsp_result;

    lsu_addr_stage addr_stage (
        .req    (issue_req),
        .access (addr_access)
    );

    lsu_elastic_buf #(
        .payload_t (staged_access_t)
    ) access_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (issue_valid),
        .in_ready  (issue_ready),
        .in_data   (addr_access),
        .out_valid (buf_valid),
        .out_ready (buf_ready),
        .out_data  (buf_access)
    );

    lsu_bus_stage bus_stage (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (buf_valid),
        .in_ready   (buf_ready),
        .in_access  (buf_access),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_sel     (wb_sel),
        .wb_dat_w   (wb_dat_w),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .done_valid (done_valid),
        .done_ready (done_ready),
        .done_ctx   (done_ctx),
        .done_word  (done_word)
    );

    lsu_rsp_stage rsp_stage (
        .ctx    (done_ctx),
        .word   (done_word),
        .result (rsp_result)
    );

    lsu_elastic_buf #(
        .payload_t (lsu_result_t)
    ) result_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (done_valid),
        .in_ready  (done_ready),
        .in_data   (rsp_result),
        .out_valid (result_valid),
        .out_ready (result_ready),
        .out_data  (result)
    );

endmodule

`default_nettype wire
